/* Makefile */
# Verilator build and run of the preview testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into sim.log, check the result"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -f sim.f --top-module preview_tb
	-./obj_dir/Vpreview_tb > sim.log 2>&1
	@grep -q "Done: no errors" sim.log || (cat sim.log; echo "simulation failed"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

/* dv/preview_props.sv */
`timescale 1ns/1ps
`default_nettype none

module preview_props (
    input logic core_clk,
    input logic sys_reset,
    input logic stream_valid_i,
    input logic push_i,
    input logic pop_i,
    input logic not_empty_i
);

    logic [3:0] occupancy_q;

    // shadow fill level of the pixel fifo
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            occupancy_q <= '0;
        end else if (push_i && !(pop_i && not_empty_i)) begin
            occupancy_q <= occupancy_q + 1'b1;
        end else if (!push_i && pop_i && not_empty_i) begin
            occupancy_q <= occupancy_q - 1'b1;
        end
    end

    stream_quiet_in_reset: assert property (@(posedge core_clk) sys_reset |=> !stream_valid_i)
        else $error("stream valid high while in reset");

    no_push_when_full: assert property (@(posedge core_clk) disable iff (sys_reset)
        push_i |-> (occupancy_q != 4'd8))
        else $error("pixel fifo pushed while full");

    no_pop_when_empty: assert property (@(posedge core_clk) disable iff (sys_reset)
        pop_i |-> (occupancy_q != 4'd0))
        else $error("pixel fifo popped while empty");

endmodule

bind preview_top preview_props u_props (
    .core_clk      (core_clk),
    .sys_reset     (sys_reset),
    .stream_valid_i(stream_valid_o),
    .push_i        (push_w),
    .pop_i         (pop_w),
    .not_empty_i   (not_empty_w)
);

`default_nettype wire

/* dv/preview_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module preview_tb;

    localparam int DRAIN_LIMIT  = 2000;
    localparam int QUIET_CYCLES = 20;

    // ascii BIVFRAME, first character goes out first
    localparam logic [63:0] HEADER = "BIVFRAME";

    logic                   core_clk = 1'b0;
    logic                   sys_reset;
    logic [7:0]             byte_i;
    logic                   byte_valid_i;
    frame_pkg::pixel_pair_t pixel_i;
    logic                   pixel_valid_i;
    logic                   sof_i;
    logic [7:0]             stream_o;
    logic                   stream_valid_o;

    logic [7:0]   expected_q[$];
    logic [255:0] owner_q[$];
    logic [255:0] test_name;
    logic [31:0]  rng_state;

    // reference model, register side and current frame
    int   cfg_width;
    int   cfg_height;
    logic cfg_both;
    int   frm_width;
    int   frm_height;
    int   frm_col;
    int   frm_row;
    logic frm_both;
    logic frm_active;

    preview_top DUT (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .byte_i        (byte_i),
        .byte_valid_i  (byte_valid_i),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .sof_i         (sof_i),
        .stream_o      (stream_o),
        .stream_valid_o(stream_valid_o)
    );

    always #20 core_clk = ~core_clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare_byte(input logic [255:0] name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (expected !== actual) begin
            $display("error: test %0s expected %02h actual %02h", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stream byte mismatch");
        end
    endtask

    task automatic bad_line(input logic [7:0] kind);
        $display("stimulus file has a malformed or unknown line of kind '%c'", kind);
        $display("Done: errors found");
        $fatal(1, "bad stimulus file");
    endtask

    task automatic push_expected(input logic [7:0] b);
        expected_q.push_back(b);
        owner_q.push_back(test_name);
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model

    task automatic model_command(input logic [31:0] addr, input logic [31:0] data);
        case (addr[15:0])
            16'h0001: cfg_width = int'(data[15:0]);
            16'h0002: cfg_height = int'(data[15:0]);
            16'h0003: cfg_both = data[0];
            default: begin
                // other addresses leave the registers alone
            end
        endcase
    endtask

    task automatic model_pixel(input logic sof, input logic [7:0] c0, input logic [7:0] c1);
        int i;
        if (sof) begin
            frm_width  = cfg_width;
            frm_height = cfg_height;
            frm_both   = cfg_both;
            frm_col    = 0;
            frm_row    = 0;
            frm_active = 1'b1;
            for (i = 0; i < 8; i++) begin
                push_expected(HEADER[63-8*i -: 8]);
            end
        end
        if (frm_active) begin
            if (frm_both) begin
                push_expected(c0);
            end
            push_expected(c1);
            if (frm_col == frm_width - 1) begin
                if (frm_row == frm_height - 1) begin
                    frm_active = 1'b0;
                end
                frm_col = 0;
                frm_row++;
            end else begin
                frm_col++;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // drivers

    task automatic send_command(input logic [31:0] addr, input logic [31:0] data);
        logic [47:0] word;
        int          i;
        // address msb on the wire first
        word = {addr[15:0], data};
        for (i = 0; i < 6; i++) begin
            @(posedge core_clk);
            byte_i       <= word[47-8*i -: 8];
            byte_valid_i <= 1'b1;
        end
        @(posedge core_clk);
        byte_valid_i <= 1'b0;
        // register lands two cycles after the sixth byte
        repeat (2) @(posedge core_clk);
        model_command(addr, data);
    endtask

    task automatic send_pixel(input logic sof, input logic [7:0] c0, input logic [7:0] c1);
        int gap;
        rng_state = next_random(rng_state);
        gap = 3 + int'(rng_state % 32'd3);
        @(posedge core_clk);
        pixel_i       <= '{ch0: c0, ch1: c1};
        pixel_valid_i <= 1'b1;
        sof_i         <= sof;
        model_pixel(sof, c0, c1);
        @(posedge core_clk);
        pixel_valid_i <= 1'b0;
        sof_i         <= 1'b0;
        repeat (gap - 2) @(posedge core_clk);
    endtask

    // every output byte must already be in the expected queue
    always @(posedge core_clk) begin
        if (!sys_reset && stream_valid_o) begin
            if (expected_q.size() == 0) begin
                $display("stream produced byte %02h when no byte was expected", stream_o);
                $display("Done: errors found");
                $fatal(1, "unexpected stream byte");
            end else begin
                compare_byte(owner_q.pop_front(), expected_q.pop_front(), stream_o);
            end
        end
    end

    initial begin
        int             fd;
        int             code;
        int             sof;
        int             cycles;
        logic [7:0]     kind;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    c;
        logic [1023:0]  skip_line;
        sys_reset     <= 1'b1;
        byte_i        <= '0;
        byte_valid_i  <= 1'b0;
        pixel_i       <= '0;
        pixel_valid_i <= 1'b0;
        sof_i         <= 1'b0;
        cfg_width  = 400;
        cfg_height = 400;
        cfg_both   = 1'b1;
        frm_active = 1'b0;
        rng_state  = 32'd45384;
        test_name  = "reset";
        repeat (5) @(posedge core_clk);
        sys_reset <= 1'b0;

        fd = $fopen("dv/preview_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/preview_testdata.txt");
            $display("Done: errors found");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1) begin
                case (kind)
                    "#": code = $fgets(skip_line, fd);
                    "T": code = $fscanf(fd, " %s", test_name);
                    "C": begin
                        code = $fscanf(fd, " %h %h", a, b);
                        if (code != 2) bad_line(kind);
                        send_command(a, b);
                    end
                    "P": begin
                        code = $fscanf(fd, " %d %h %h", sof, b, c);
                        if (code != 3) bad_line(kind);
                        send_pixel(sof != 0, b[7:0], c[7:0]);
                    end
                    "W": begin
                        code = $fscanf(fd, " %d", cycles);
                        if (code != 1) bad_line(kind);
                        repeat (cycles) @(posedge core_clk);
                    end
                    default: bad_line(kind);
                endcase
            end
        end
        $fclose(fd);

        // drain with a bound
        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge core_clk);
            cycles++;
        end
        // stray bytes here trip the monitor
        repeat (QUIET_CYCLES) @(posedge core_clk);
        if (expected_q.size() != 0) begin
            $display("%0d expected stream bytes never appeared, first one from test %0s",
                     expected_q.size(), owner_q[0]);
            $display("Done: errors found");
            $fatal(1, "stream incomplete");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/preview_testdata.txt */
# C addr data | P sof ch0 ch1 | W idle_cycles | T test_name
# addr, data, ch0 and ch1 in hex; sof and idle_cycles in decimal
T no_sof_drop
P 0 e0 e1
P 0 e2 e3
W 6
T small_frame
C 0001 00000004
C 0002 00000003
W 4
P 1 01 81
P 0 02 82
P 0 03 83
P 0 04 84
P 0 05 85
P 0 06 86
P 0 07 87
P 0 08 88
P 0 09 89
P 0 0a 8a
P 0 0b 8b
P 0 0c 8c
T overrun_drop
P 0 f0 f1
P 0 f2 f3
W 20
T single_channel
C 0001 00000002
C 0002 00000002
C 0003 00000000
W 4
P 1 21 31
P 0 22 32
P 0 23 33
P 0 24 34
W 20
T cfg_midframe
C 0003 00000001
W 4
P 1 41 51
P 0 42 52
C 0001 00000003
P 0 43 53
P 0 44 54
P 0 45 55
W 20
T cfg_next_sof
C 0002 00000001
W 4
P 1 61 71
P 0 62 72
P 0 63 73
W 20
T unknown_addr
C 0000 0000ffff
C 0004 00000000
W 4
P 1 a1 b1
P 0 a2 b2
P 0 a3 b3
P 0 a4 b4
T back_to_back
W 12
P 1 c1 d1
P 0 c2 d2
P 0 c3 d3
W 20

/* hw/cmd_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_assembler (
    input  logic          core_clk,
    input  logic          sys_reset,
    input  logic [7:0]    byte_i,
    input  logic          byte_valid_i,
    output cmd_pkg::cmd_t cmd_o,
    output logic          cmd_valid_o
);

    typedef logic [$clog2(cmd_pkg::CMD_BYTES)-1:0] cnt_t;

    cnt_t          byte_cnt_q;
    cmd_pkg::cmd_t shift_q;

    // byte count and command strobe
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt_q  <= '0;
            cmd_valid_o <= 1'b0;
        end else begin
            cmd_valid_o <= 1'b0;
            if (byte_valid_i) begin
                if (byte_cnt_q == cnt_t'(cmd_pkg::CMD_BYTES - 1)) begin
                    byte_cnt_q  <= '0;
                    cmd_valid_o <= 1'b1;
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

    // oldest byte drifts up into the address msb
    always_ff @(posedge core_clk) begin
        if (byte_valid_i) begin
            shift_q <= {shift_q[$bits(shift_q)-9:0], byte_i};
        end
    end

    assign cmd_o = shift_q;

endmodule

`default_nettype wire

/* hw/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

    localparam int unsigned CMD_BYTES = 6;
    localparam int unsigned ADDR_W    = 16;
    localparam int unsigned DATA_W    = 32;

    // address sits in the upper bytes, first byte on the wire is its msb
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } cmd_t;

    typedef enum logic [ADDR_W-1:0] {
        OP_SET_WIDTH    = 16'h0001,
        OP_SET_HEIGHT   = 16'h0002,
        OP_SET_CHANNELS = 16'h0003
    } cmd_op_e;

    typedef struct packed {
        logic [frame_pkg::DIM_W-1:0] width;
        logic [frame_pkg::DIM_W-1:0] height;
        logic                        both_channels;
    } frame_cfg_t;

    // register values out of reset
    localparam frame_cfg_t CFG_RESET = '{
        width:         frame_pkg::DEFAULT_WIDTH,
        height:        frame_pkg::DEFAULT_HEIGHT,
        both_channels: 1'b1
    };

endpackage

`default_nettype wire

/* hw/frame_config_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_config_regs (
    input  logic                core_clk,
    input  logic                sys_reset,
    input  cmd_pkg::cmd_t       cmd_i,
    input  logic                cmd_valid_i,
    output cmd_pkg::frame_cfg_t cfg_o
);

    cmd_pkg::cmd_op_e    op;
    cmd_pkg::frame_cfg_t cfg_q;

    assign op = cmd_pkg::cmd_op_e'(cmd_i.addr);

    // register write decode
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            cfg_q <= cmd_pkg::CFG_RESET;
        end else if (cmd_valid_i) begin
            case (op)
                cmd_pkg::OP_SET_WIDTH: begin
                    cfg_q.width <= cmd_i.data[frame_pkg::DIM_W-1:0];
                end
                cmd_pkg::OP_SET_HEIGHT: begin
                    cfg_q.height <= cmd_i.data[frame_pkg::DIM_W-1:0];
                end
                cmd_pkg::OP_SET_CHANNELS: begin
                    // bit 0 low means ch1 only
                    cfg_q.both_channels <= cmd_i.data[0];
                end
                default: begin
                    // unknown address, nothing to update
                end
            endcase
        end
    end

    // consumers copy this at sof, so a change here never splits a frame
    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

/* hw/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    //////////////////////////////////////////////////////////////////////
    // pixel data

    localparam int unsigned PIXEL_W = 8;
    localparam int unsigned DIM_W   = 16;

    // one strobe carries both cameras
    typedef struct packed {
        logic [PIXEL_W-1:0] ch0;
        logic [PIXEL_W-1:0] ch1;
    } pixel_pair_t;

    // frame boundaries travel with the pixel through the fifo
    typedef struct packed {
        pixel_pair_t pair;
        logic        first;
        logic        last;
    } tagged_pixel_t;

    localparam int unsigned FIFO_DEPTH = 8;

    localparam logic [DIM_W-1:0] DEFAULT_WIDTH  = 16'd400;
    localparam logic [DIM_W-1:0] DEFAULT_HEIGHT = 16'd400;

    //////////////////////////////////////////////////////////////////////
    // preview framing

    // ascii BIVFRAME, most significant byte goes out first
    localparam logic [63:0] MAGIC_NUM   = 64'h42_49_56_46_52_41_4D_45;
    localparam int unsigned MAGIC_BYTES = 8;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PIX_CH0,
        ST_PIX_CH1
    } frame_state_e;

endpackage

`default_nettype wire

/* hw/frame_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
    input  logic                          core_clk,
    input  logic                          sys_reset,
    input  logic                          not_empty_i,
    input  frame_pkg::tagged_pixel_t      entry_i,
    input  cmd_pkg::frame_cfg_t           cfg_i,
    output logic                          pop_o,
    output logic [frame_pkg::PIXEL_W-1:0] stream_o,
    output logic                          stream_valid_o
);

    typedef logic [$clog2(frame_pkg::MAGIC_BYTES)-1:0] idx_t;

    frame_pkg::frame_state_e       state_q;
    frame_pkg::tagged_pixel_t      hold_q;
    idx_t                          hdr_idx_q;
    logic                          have_q;
    logic                          fetch_q;
    logic                          both_q;
    logic [frame_pkg::PIXEL_W-1:0] byte_d;

    // next pop may overlap the final byte of the held pixel
    assign pop_o = not_empty_i && !fetch_q &&
                   (!have_q || (state_q == frame_pkg::ST_PIX_CH1));

    always_comb begin
        case (state_q)
            frame_pkg::ST_HEADER:  byte_d = frame_pkg::MAGIC_NUM[63 - 8*hdr_idx_q -: 8];
            frame_pkg::ST_PIX_CH0: byte_d = hold_q.pair.ch0;
            default:               byte_d = hold_q.pair.ch1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state machine, one byte per cycle while an entry is held

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state_q        <= frame_pkg::ST_IDLE;
            hdr_idx_q      <= '0;
            have_q         <= 1'b0;
            fetch_q        <= 1'b0;
            both_q         <= 1'b1;
            stream_valid_o <= 1'b0;
        end else begin
            fetch_q        <= pop_o;
            stream_valid_o <= have_q;
            if (have_q) begin
                case (state_q)
                    frame_pkg::ST_HEADER: begin
                        hdr_idx_q <= hdr_idx_q + 1'b1;
                        if (hdr_idx_q == idx_t'(frame_pkg::MAGIC_BYTES - 1)) begin
                            state_q <= both_q ? frame_pkg::ST_PIX_CH0 : frame_pkg::ST_PIX_CH1;
                        end
                    end
                    frame_pkg::ST_PIX_CH0: state_q <= frame_pkg::ST_PIX_CH1;
                    frame_pkg::ST_PIX_CH1: begin
                        have_q <= 1'b0;
                        if (hold_q.last) begin
                            state_q <= frame_pkg::ST_IDLE;
                        end else begin
                            state_q <= both_q ? frame_pkg::ST_PIX_CH0 : frame_pkg::ST_PIX_CH1;
                        end
                    end
                    default: have_q <= 1'b0;
                endcase
            end
            if (fetch_q) begin
                if (entry_i.first) begin
                    // channel mode latched once per frame
                    state_q   <= frame_pkg::ST_HEADER;
                    hdr_idx_q <= '0;
                    both_q    <= cfg_i.both_channels;
                    have_q    <= 1'b1;
                end else if (state_q != frame_pkg::ST_IDLE) begin
                    have_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (fetch_q) hold_q <= entry_i;
        stream_o <= byte_d;
    end

endmodule

`default_nettype wire

/* hw/pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  logic                     push_i,
    input  frame_pkg::tagged_pixel_t entry_i,
    input  logic                     pop_i,
    output frame_pkg::tagged_pixel_t entry_o,
    output logic                     not_empty_o
);

    typedef logic [$clog2(frame_pkg::FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(frame_pkg::FIFO_DEPTH+1)-1:0] cnt_t;

    frame_pkg::tagged_pixel_t mem [frame_pkg::FIFO_DEPTH];
    ptr_t                     wr_ptr_q;
    ptr_t                     rd_ptr_q;
    cnt_t                     count_q;
    logic                     full;
    logic                     wr_en;
    logic                     rd_en;

    assign full        = (count_q == cnt_t'(frame_pkg::FIFO_DEPTH));
    assign not_empty_o = (count_q != '0);
    assign wr_en       = push_i && !full;
    assign rd_en       = pop_i && not_empty_o;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
            if (wr_en && !rd_en) count_q <= count_q + 1'b1;
            if (rd_en && !wr_en) count_q <= count_q - 1'b1;
        end
    end

    // popped entry shows up on the next cycle
    always_ff @(posedge core_clk) begin
        if (wr_en) mem[wr_ptr_q] <= entry_i;
        if (rd_en) entry_o <= mem[rd_ptr_q];
    end

endmodule

`default_nettype wire

/* hw/pixel_position_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_position_counter (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  frame_pkg::pixel_pair_t   pixel_i,
    input  logic                     pixel_valid_i,
    input  logic                     sof_i,
    input  cmd_pkg::frame_cfg_t      cfg_i,
    output logic                     push_o,
    output frame_pkg::tagged_pixel_t entry_o
);

    logic [frame_pkg::DIM_W-1:0] col_q;
    logic [frame_pkg::DIM_W-1:0] row_q;
    logic [frame_pkg::DIM_W-1:0] width_q;
    logic [frame_pkg::DIM_W-1:0] height_q;
    logic                        active_q;

    logic [frame_pkg::DIM_W-1:0] cur_col;
    logic [frame_pkg::DIM_W-1:0] cur_row;
    logic [frame_pkg::DIM_W-1:0] cur_width;
    logic [frame_pkg::DIM_W-1:0] cur_height;
    logic                        accept;
    logic                        col_end;
    logic                        is_last;

    always_comb begin
        // sof restarts at 0,0 with whatever dims are configured right now
        cur_col    = sof_i ? '0 : col_q;
        cur_row    = sof_i ? '0 : row_q;
        cur_width  = sof_i ? cfg_i.width : width_q;
        cur_height = sof_i ? cfg_i.height : height_q;
        // pixels outside a frame are dropped
        accept     = pixel_valid_i && (sof_i || active_q);
        col_end    = (cur_col == cur_width - 1'b1);
        is_last    = col_end && (cur_row == cur_height - 1'b1);
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col_q    <= '0;
            row_q    <= '0;
            width_q  <= frame_pkg::DEFAULT_WIDTH;
            height_q <= frame_pkg::DEFAULT_HEIGHT;
            active_q <= 1'b0;
            push_o   <= 1'b0;
        end else begin
            push_o <= accept;
            if (accept) begin
                width_q  <= cur_width;
                height_q <= cur_height;
                active_q <= !is_last;
                if (col_end) begin
                    col_q <= '0;
                    row_q <= cur_row + 1'b1;
                end else begin
                    col_q <= cur_col + 1'b1;
                    row_q <= cur_row;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            entry_o <= '{pair: pixel_i, first: sof_i, last: is_last};
        end
    end

endmodule

`default_nettype wire

/* hw/preview_top.sv */
`timescale 1ns/1ps
`default_nettype none

module preview_top (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  logic [7:0]             byte_i,
    input  logic                   byte_valid_i,
    input  frame_pkg::pixel_pair_t pixel_i,
    input  logic                   pixel_valid_i,
    input  logic                   sof_i,
    output logic [7:0]             stream_o,
    output logic                   stream_valid_o
);

    cmd_pkg::cmd_t            cmd_w;
    logic                     cmd_valid_w;
    cmd_pkg::frame_cfg_t      cfg_w;
    logic                     push_w;
    frame_pkg::tagged_pixel_t push_entry_w;
    logic                     pop_w;
    logic                     not_empty_w;
    frame_pkg::tagged_pixel_t pop_entry_w;

    //////////////////////////////////////////////////////////////////////
    // command port into the config registers

    cmd_assembler u_cmd (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .byte_i      (byte_i),
        .byte_valid_i(byte_valid_i),
        .cmd_o       (cmd_w),
        .cmd_valid_o (cmd_valid_w)
    );

    frame_config_regs u_regs (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .cmd_i      (cmd_w),
        .cmd_valid_i(cmd_valid_w),
        .cfg_o      (cfg_w)
    );

    //////////////////////////////////////////////////////////////////////
    // pixel path, counter to fifo to framer

    pixel_position_counter u_counter (
        .core_clk     (core_clk),
        .sys_reset    (sys_reset),
        .pixel_i      (pixel_i),
        .pixel_valid_i(pixel_valid_i),
        .sof_i        (sof_i),
        .cfg_i        (cfg_w),
        .push_o       (push_w),
        .entry_o      (push_entry_w)
    );

    pixel_fifo u_fifo (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .push_i     (push_w),
        .entry_i    (push_entry_w),
        .pop_i      (pop_w),
        .entry_o    (pop_entry_w),
        .not_empty_o(not_empty_w)
    );

    frame_sequencer u_seq (
        .core_clk      (core_clk),
        .sys_reset     (sys_reset),
        .not_empty_i   (not_empty_w),
        .entry_i       (pop_entry_w),
        .cfg_i         (cfg_w),
        .pop_o         (pop_w),
        .stream_o      (stream_o),
        .stream_valid_o(stream_valid_o)
    );

endmodule

`default_nettype wire

/* sim.f */
hw/frame_pkg.sv
hw/cmd_pkg.sv
hw/cmd_assembler.sv
hw/frame_config_regs.sv
hw/pixel_position_counter.sv
hw/pixel_fifo.sv
hw/frame_sequencer.sv
hw/preview_top.sv
dv/preview_props.sv
dv/preview_tb.sv
